//--- mips_macros.svh
/*
 * widths, reset pc and syscall constants for the mips core
 * the datapath assumes a 32-bit word and 5-bit register numbers
 */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// data word and register number widths
`define MIPS_WORD_W 32
`define MIPS_REG_ADDR_W 5

// pc after reset, start of the text segment
`define MIPS_TEXT_START 32'h0040_0000

// $v0 value that makes a syscall halt
`define MIPS_EXIT_CODE 32'd10

// destination of jal
`define MIPS_LINK_REG 5'd31

`endif

//--- mips_isa_pkg.sv
/*
 * encodings of the kept mips instruction subset
 * codes outside these enums are reserved
 */
`default_nettype none

package mips_isa_pkg;

   // primary opcode, inst[31:26]
   typedef enum logic [5:0] {
      OP_RTYPE  = 6'h00,
      OP_REGIMM = 6'h01,
      OP_J      = 6'h02,
      OP_JAL    = 6'h03,
      OP_BEQ    = 6'h04,
      OP_BNE    = 6'h05,
      OP_BLEZ   = 6'h06,
      OP_BGTZ   = 6'h07,
      OP_ADDI   = 6'h08,
      OP_ADDIU  = 6'h09,
      OP_SLTI   = 6'h0a,
      OP_ANDI   = 6'h0c,
      OP_ORI    = 6'h0d,
      OP_XORI   = 6'h0e,
      OP_LUI    = 6'h0f,
      OP_LB     = 6'h20,
      OP_LH     = 6'h21,
      OP_LW     = 6'h23,
      OP_LBU    = 6'h24,
      OP_LHU    = 6'h25,
      OP_SB     = 6'h28,
      OP_SH     = 6'h29,
      OP_SW     = 6'h2b
   } opcode_e;

   // r-type function, inst[5:0]
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SLLV    = 6'h04,
      FN_SRLV    = 6'h06,
      FN_SRAV    = 6'h07,
      FN_JR      = 6'h08,
      FN_JALR    = 6'h09,
      FN_SYSCALL = 6'h0c,
      FN_ADD     = 6'h20,
      FN_ADDU    = 6'h21,
      FN_SUB     = 6'h22,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a
   } funct_e;

   // regimm selector in the rt field
   typedef enum logic [4:0] {
      RI_BLTZ = 5'h00,
      RI_BGEZ = 5'h01
   } regimm_e;

endpackage

`default_nettype wire

//--- mips_ctrl_pkg.sv
/*
 * control vocabulary between decoder and datapath
 * encodings are internal only
 */
`default_nettype none

package mips_ctrl_pkg;

   // alu_lui places the immediate in the upper half
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB,
      ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_SLLV, ALU_SRLV, ALU_SRAV,
      ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_LUI
   } alu_op_e;

   // branch condition on rs, and rt for eq/ne
   typedef enum logic [2:0] {
      BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
   } branch_e;

   // source of the pc after the delay slot
   typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_REG, PC_JUMP} pc_sel_e;

   // register write-back source
   typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wb_sel_e;

   typedef enum logic [1:0] {MEM_NONE, MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

endpackage

`default_nettype wire

//--- mips_ctrl_if.sv
/*
 * decoded control bundle, decoder to datapath
 * purely combinational, no clock
 */
`default_nettype none
`timescale 1ns/1ps

interface mips_ctrl_if;
   import mips_ctrl_pkg::*;

   logic      reg_write;
   // rd when set, else rt (or the link register)
   logic      dst_rd;
   logic      imm_sign;
   logic      alu_src_imm;
   alu_op_e   alu_op;
   branch_e   branch;
   pc_sel_e   pc_sel;
   wb_sel_e   wb_sel;
   mem_size_e mem_size;
   logic      mem_unsigned;
   logic      mem_store;
   logic      syscall;
   logic      reserved;

   modport dec (
      output reg_write, dst_rd, imm_sign, alu_src_imm, alu_op, branch, pc_sel,
      output wb_sel, mem_size, mem_unsigned, mem_store, syscall, reserved
   );

   modport dp (
      input reg_write, dst_rd, imm_sign, alu_src_imm, alu_op, branch, pc_sel,
      input wb_sel, mem_size, mem_unsigned, mem_store, syscall, reserved
   );

endinterface

`default_nettype wire

//--- mips_decode.sv
/*
 * combinational decode of the kept mips subset
 * anything else raises reserved with no write or branch
 */
`default_nettype none
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_decode (
   input  wire logic [`MIPS_WORD_W-1:0] inst,
   mips_ctrl_if.dec                     ctrl
);
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   opcode_e   op;
   funct_e    fn;
   regimm_e   ri;
   mem_size_e acc_size;

   assign op = opcode_e'(inst[31:26]);
   assign fn = funct_e'(inst[5:0]);
   assign ri = regimm_e'(inst[20:16]);

   // load/store size sits in opcode bits 1:0
   // 00 byte, 01 half, 11 word
   assign acc_size = inst[27] ? MEM_WORD : (inst[26] ? MEM_HALF : MEM_BYTE);

   always_comb begin
      // a nop-like bundle unless a case says otherwise
      ctrl.reg_write    = 1'b0;
      ctrl.dst_rd       = 1'b0;
      ctrl.imm_sign     = 1'b0;
      ctrl.alu_src_imm  = 1'b0;
      ctrl.alu_op       = ALU_ADD;
      ctrl.branch       = BR_NONE;
      ctrl.pc_sel       = PC_SEQ;
      ctrl.wb_sel       = WB_ALU;
      ctrl.mem_size     = MEM_NONE;
      ctrl.mem_unsigned = 1'b0;
      ctrl.mem_store    = 1'b0;
      ctrl.syscall      = 1'b0;
      ctrl.reserved     = 1'b0;
      case (op)
         OP_RTYPE: begin
            ctrl.reg_write = 1'b1;
            ctrl.dst_rd    = 1'b1;
            case (fn)
               FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;
               FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
               FN_AND:  ctrl.alu_op = ALU_AND;
               FN_OR:   ctrl.alu_op = ALU_OR;
               FN_XOR:  ctrl.alu_op = ALU_XOR;
               FN_NOR:  ctrl.alu_op = ALU_NOR;
               FN_SLT:  ctrl.alu_op = ALU_SLT;
               FN_SLL:  ctrl.alu_op = ALU_SLL;
               FN_SRL:  ctrl.alu_op = ALU_SRL;
               FN_SRA:  ctrl.alu_op = ALU_SRA;
               FN_SLLV: ctrl.alu_op = ALU_SLLV;
               FN_SRLV: ctrl.alu_op = ALU_SRLV;
               FN_SRAV: ctrl.alu_op = ALU_SRAV;
               FN_JR: begin
                  ctrl.reg_write = 1'b0;
                  ctrl.pc_sel    = PC_REG;
               end
               // links into rd
               FN_JALR: begin
                  ctrl.pc_sel = PC_REG;
                  ctrl.wb_sel = WB_LINK;
               end
               FN_SYSCALL: begin
                  ctrl.reg_write = 1'b0;
                  ctrl.syscall   = 1'b1;
               end
               default: begin
                  ctrl.reg_write = 1'b0;
                  ctrl.reserved  = 1'b1;
               end
            endcase
         end
         OP_REGIMM: begin
            ctrl.pc_sel   = PC_BRANCH;
            // branch offsets sign-extend
            ctrl.imm_sign = 1'b1;
            case (ri)
               RI_BLTZ: ctrl.branch = BR_LTZ;
               RI_BGEZ: ctrl.branch = BR_GEZ;
               default: ctrl.reserved = 1'b1;
            endcase
         end
         OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
            ctrl.pc_sel   = PC_BRANCH;
            ctrl.imm_sign = 1'b1;
            case (op)
               OP_BEQ:  ctrl.branch = BR_EQ;
               OP_BNE:  ctrl.branch = BR_NE;
               OP_BLEZ: ctrl.branch = BR_LEZ;
               default: ctrl.branch = BR_GTZ;
            endcase
         end
         OP_J: ctrl.pc_sel = PC_JUMP;
         // dst_rd stays low, so the link register is picked
         OP_JAL: begin
            ctrl.pc_sel    = PC_JUMP;
            ctrl.reg_write = 1'b1;
            ctrl.wb_sel    = WB_LINK;
         end
         OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            ctrl.reg_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            // logical immediates zero-extend
            ctrl.imm_sign    = (op == OP_ADDI) || (op == OP_ADDIU) || (op == OP_SLTI);
            case (op)
               OP_SLTI: ctrl.alu_op = ALU_SLT;
               OP_ANDI: ctrl.alu_op = ALU_AND;
               OP_ORI:  ctrl.alu_op = ALU_OR;
               OP_XORI: ctrl.alu_op = ALU_XOR;
               OP_LUI:  ctrl.alu_op = ALU_LUI;
               default: ctrl.alu_op = ALU_ADD;
            endcase
         end
         // address is rs plus the sign-extended offset through the default alu add
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
            ctrl.reg_write    = 1'b1;
            ctrl.alu_src_imm  = 1'b1;
            ctrl.imm_sign     = 1'b1;
            ctrl.wb_sel       = WB_LOAD;
            ctrl.mem_size     = acc_size;
            ctrl.mem_unsigned = inst[28];
         end
         OP_SB, OP_SH, OP_SW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm_sign    = 1'b1;
            ctrl.mem_store   = 1'b1;
            ctrl.mem_size    = acc_size;
         end
         default: ctrl.reserved = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

//--- mips_alu.sv
/*
 * single-cycle alu, no overflow detection
 * shifts act on op_b, the rt operand
 */
`default_nettype none
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_alu (
   input  wire logic [`MIPS_WORD_W-1:0] op_a,
   input  wire logic [`MIPS_WORD_W-1:0] op_b,
   input  wire logic [4:0]              shamt,
   input  wire mips_ctrl_pkg::alu_op_e  alu_op,
   output logic [`MIPS_WORD_W-1:0]      result
);
   import mips_ctrl_pkg::*;

   logic [4:0] var_amt;
   logic       lt;

   // variable shifts use the low five bits of rs
   assign var_amt = op_a[4:0];
   assign lt      = $signed(op_a) < $signed(op_b);

   always_comb begin
      case (alu_op)
         ALU_ADD:  result = op_a + op_b;
         ALU_SUB:  result = op_a - op_b;
         ALU_SLL:  result = op_b << shamt;
         ALU_SRL:  result = op_b >> shamt;
         ALU_SRA:  result = $signed(op_b) >>> shamt;
         ALU_SLLV: result = op_b << var_amt;
         ALU_SRLV: result = op_b >> var_amt;
         ALU_SRAV: result = $signed(op_b) >>> var_amt;
         ALU_AND:  result = op_a & op_b;
         ALU_OR:   result = op_a | op_b;
         ALU_XOR:  result = op_a ^ op_b;
         ALU_NOR:  result = ~(op_a | op_b);
         // signed compare, 0 or 1
         ALU_SLT:  result = {{(`MIPS_WORD_W-1){1'b0}}, lt};
         // immediate into the upper half
         ALU_LUI:  result = {op_b[15:0], 16'h0000};
         default:  result = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- mips_regfile.sv
/*
 * 32 x 32 register file, $zero hard-wired
 * reads see the value from before this cycle's write
 */
`default_nettype none
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_regfile (
   input  wire logic                       clk,
   input  wire logic                       rst_b,
   input  wire logic [`MIPS_REG_ADDR_W-1:0] rs_addr,
   input  wire logic [`MIPS_REG_ADDR_W-1:0] rt_addr,
   input  wire logic [`MIPS_REG_ADDR_W-1:0] wr_addr,
   input  wire logic                       wr_en,
   input  wire logic [`MIPS_WORD_W-1:0]    wr_data,
   output logic [`MIPS_WORD_W-1:0]         rs_data,
   output logic [`MIPS_WORD_W-1:0]         rt_data,
   output logic [`MIPS_WORD_W-1:0]         v0_data
);

   logic [`MIPS_WORD_W-1:0] regs [2**`MIPS_REG_ADDR_W];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 2**`MIPS_REG_ADDR_W; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_addr != '0)) begin
         // register 0 never written, stays zero
         regs[wr_addr] <= wr_data;
      end
   end

   assign rs_data = regs[rs_addr];
   assign rt_data = regs[rt_addr];
   // $v0 is register 2, the syscall code
   assign v0_data = regs[2];

endmodule

`default_nettype wire

//--- mips_mem_align.sv
/*
 * big-endian lane handling, byte offset 0 is bits 31:24
 * halfword and word accesses are assumed aligned
 */
`default_nettype none
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_mem_align (
   input  wire logic [1:0]               byte_off,
   input  wire mips_ctrl_pkg::mem_size_e mem_size,
   input  wire logic                     mem_unsigned,
   input  wire logic                     mem_store,
   input  wire logic [`MIPS_WORD_W-1:0]  store_src,
   input  wire logic [`MIPS_WORD_W-1:0]  mem_rdata,
   output logic [`MIPS_WORD_W-1:0]       load_data,
   output logic [`MIPS_WORD_W-1:0]       wdata,
   output logic [3:0]                    wen
);
   import mips_ctrl_pkg::*;

   logic [7:0]  byte_val;
   logic [15:0] half_val;

   // offset 0 picks the top byte, so index by the inverted offset
   assign byte_val = mem_rdata[{~byte_off, 3'b000} +: 8];
   assign half_val = mem_rdata[{~byte_off[1], 4'b0000} +: 16];

   always_comb begin
      case (mem_size)
         MEM_BYTE:
            load_data = mem_unsigned ? {24'h0, byte_val} : {{24{byte_val[7]}}, byte_val};
         MEM_HALF:
            load_data = mem_unsigned ? {16'h0, half_val} : {{16{half_val[15]}}, half_val};
         default:
            load_data = mem_rdata;
      endcase
   end

   // store data copied to every lane, the mask picks the live one
   always_comb begin
      wdata = store_src;
      wen   = 4'b0000;
      if (mem_store) begin
         case (mem_size)
            MEM_BYTE: begin
               wdata = {4{store_src[7:0]}};
               wen   = 4'b1000 >> byte_off;
            end
            MEM_HALF: begin
               wdata = {2{store_src[15:0]}};
               wen   = byte_off[1] ? 4'b0011 : 4'b1100;
            end
            MEM_WORD: wen = 4'b1111;
            default:  wen = 4'b0000;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- mips_core.sv
/*
 * single-cycle mips core with one branch delay slot
 * memories are combinational, addresses are word addresses
 * a branch in a delay slot is not supported
 */
`default_nettype none
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_core (
   input  wire logic                    clk,
   input  wire logic                    rst_b,
   output logic [`MIPS_WORD_W-3:0]      inst_addr,
   input  wire logic [`MIPS_WORD_W-1:0] inst,
   input  wire logic                    inst_excpt,
   output logic [`MIPS_WORD_W-3:0]      mem_addr,
   output logic [`MIPS_WORD_W-1:0]      mem_data_in,
   output logic [3:0]                   mem_write_en,
   input  wire logic [`MIPS_WORD_W-1:0] mem_data_out,
   output logic                         halted
);
   import mips_ctrl_pkg::*;

   // pc executes now, npc is the delay slot
   logic [`MIPS_WORD_W-1:0]     pc;
   logic [`MIPS_WORD_W-1:0]     npc;
   logic [`MIPS_WORD_W-1:0]     nnpc;
   logic [`MIPS_WORD_W-1:0]     pc_plus4;
   logic [`MIPS_WORD_W-1:0]     br_target;
   logic [`MIPS_WORD_W-1:0]     jmp_target;
   logic [`MIPS_WORD_W-1:0]     imm_ext;
   logic [`MIPS_WORD_W-1:0]     rs_data;
   logic [`MIPS_WORD_W-1:0]     rt_data;
   logic [`MIPS_WORD_W-1:0]     v0_data;
   logic [`MIPS_WORD_W-1:0]     alu_b;
   logic [`MIPS_WORD_W-1:0]     alu_result;
   logic [`MIPS_WORD_W-1:0]     load_data;
   logic [`MIPS_WORD_W-1:0]     wb_data;
   logic [`MIPS_REG_ADDR_W-1:0] wr_addr;
   logic                        br_taken;
   logic                        halt_req;
   logic                        frozen;

   mips_ctrl_if ctrl_bus ();

   mips_decode u_decode (
      .inst (inst),
      .ctrl (ctrl_bus.dec)
   );

   // halt sources, syscall only with the exit code in $v0
   assign halt_req = (ctrl_bus.syscall && (v0_data == `MIPS_EXIT_CODE))
                   || ctrl_bus.reserved || inst_excpt || (pc[1:0] != 2'b00);
   // the halting instruction itself writes nothing
   assign frozen   = halt_req || halted;

   assign imm_ext = ctrl_bus.imm_sign ? {{16{inst[15]}}, inst[15:0]} : {16'h0, inst[15:0]};
   assign alu_b   = ctrl_bus.alu_src_imm ? imm_ext : rt_data;

   // destination: rd, link register for jal, else rt
   assign wr_addr = ctrl_bus.dst_rd ? inst[15:11]
                  : ((ctrl_bus.wb_sel == WB_LINK) ? `MIPS_LINK_REG : inst[20:16]);

   always_comb begin
      case (ctrl_bus.wb_sel)
         WB_LOAD: wb_data = load_data;
         // link skips the delay slot
         WB_LINK: wb_data = pc + 32'd8;
         default: wb_data = alu_result;
      endcase
   end

   mips_regfile u_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_addr (inst[25:21]),
      .rt_addr (inst[20:16]),
      .wr_addr (wr_addr),
      .wr_en   (ctrl_bus.reg_write && !frozen),
      .wr_data (wb_data),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .v0_data (v0_data)
   );

   mips_alu u_alu (
      .op_a   (rs_data),
      .op_b   (alu_b),
      .shamt  (inst[10:6]),
      .alu_op (ctrl_bus.alu_op),
      .result (alu_result)
   );

   mips_mem_align u_mem_align (
      .byte_off     (alu_result[1:0]),
      .mem_size     (ctrl_bus.mem_size),
      .mem_unsigned (ctrl_bus.mem_unsigned),
      .mem_store    (ctrl_bus.mem_store && !frozen),
      .store_src    (rt_data),
      .mem_rdata    (mem_data_out),
      .load_data    (load_data),
      .wdata        (mem_data_in),
      .wen          (mem_write_en)
   );

   assign inst_addr = pc[`MIPS_WORD_W-1:2];
   assign mem_addr  = alu_result[`MIPS_WORD_W-1:2];

   // branch condition on rs, rt only for eq/ne
   always_comb begin
      case (ctrl_bus.branch)
         BR_EQ:   br_taken = rs_data == rt_data;
         BR_NE:   br_taken = rs_data != rt_data;
         BR_LEZ:  br_taken = rs_data[31] || (rs_data == '0);
         BR_GTZ:  br_taken = !rs_data[31] && (rs_data != '0);
         BR_LTZ:  br_taken = rs_data[31];
         BR_GEZ:  br_taken = !rs_data[31];
         default: br_taken = 1'b0;
      endcase
   end

   // targets relative to the delay slot address
   assign pc_plus4   = pc + 32'd4;
   assign br_target  = pc_plus4 + {imm_ext[29:0], 2'b00};
   assign jmp_target = {pc_plus4[31:28], inst[25:0], 2'b00};

   always_comb begin
      case (ctrl_bus.pc_sel)
         PC_BRANCH: nnpc = br_taken ? br_target : npc + 32'd4;
         PC_REG:    nnpc = rs_data;
         PC_JUMP:   nnpc = jmp_target;
         default:   nnpc = npc + 32'd4;
      endcase
   end

   // pc pair holds on a halt request so inst_addr shows the halting pc
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= `MIPS_TEXT_START;
         npc    <= `MIPS_TEXT_START + 32'd4;
         halted <= 1'b0;
      end else if (!halted) begin
         halted <= halt_req;
         if (!halt_req) begin
            pc  <= npc;
            npc <= nnpc;
         end
      end
   end

endmodule

`default_nettype wire

//--- tb_clkgen.sv
/*
 * clock and reset source for the testbench, 8 ns period
 * rst_b starts low and is released only by pulse_reset
 */
`default_nettype none
`timescale 1ns/1ps

module tb_clkgen (
   output logic clk,
   output logic rst_b
);

   initial begin
      clk   = 1'b0;
      rst_b = 1'b0;
   end

   always #4 clk = ~clk;

   // reset held for 10 cycles, released just after an edge
   task pulse_reset;
      rst_b = 1'b0;
      repeat (10) @(posedge clk);
      #1 rst_b = 1'b1;
   endtask

endmodule

`default_nettype wire

//--- tb_mips_core.sv
/*
 * runs both golden programs on the core, checks every store and the halt pc
 * mips_golden.txt is read from the directory the simulator starts in
 */
`default_nettype none
`timescale 1ns/1ps
`include "mips_macros.svh"

module tb_mips_core;

   logic                    clk;
   logic                    rst_b;
   logic [29:0]             inst_addr;
   logic [31:0]             inst;
   logic                    inst_excpt;
   logic [29:0]             mem_addr;
   logic [31:0]             mem_data_in;
   logic [3:0]              mem_write_en;
   logic [31:0]             mem_data_out;
   logic                    halted;

   // golden image with the header at 0 and programs and records at fixed bases
   logic [31:0] golden [128];
   logic [31:0] imem [64];
   logic [31:0] dmem [256];
   logic [29:0] fetch_off;

   int rec_ptr;
   int rec_cnt;
   int rec_total;
   int limit_cycles;

   tb_clkgen u_clkgen (
      .clk   (clk),
      .rst_b (rst_b)
   );

   mips_core i_dut (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .inst_excpt   (inst_excpt),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en),
      .mem_data_out (mem_data_out),
      .halted       (halted)
   );

   // instruction memory with a fetch error outside the 64-word window
   always_comb begin
      fetch_off  = inst_addr - 30'(`MIPS_TEXT_START >> 2);
      inst_excpt = (fetch_off >= 30'd64);
      inst       = imem[fetch_off[5:0]];
   end

   // data memory read is combinational
   always_comb mem_data_out = dmem[mem_addr[7:0]];

   // per-lane write where lane 3 is bits 31:24
   always @(posedge clk) begin
      if (rst_b) begin
         for (int b = 0; b < 4; b++) begin
            if (mem_write_en[b]) begin
               dmem[mem_addr[7:0]][b*8 +: 8] <= mem_data_in[b*8 +: 8];
            end
         end
      end
   end

   function automatic logic [31:0] lane_bits(input logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   task abort_run;
      $display("STATUS: FAIL");
      $fatal(1, "run stopped on error");
   endtask

   task report_mismatch(input string msg);
      $display("FAILED at %0t ns: %s", $time, msg);
      abort_run();
   endtask

   // compare one store against the next golden record
   task check_store;
      logic [31:0] exp_addr;
      logic [31:0] exp_data;
      logic [3:0]  exp_mask;
      logic [31:0] got_data;
      assert (rec_cnt < rec_total) else
         report_mismatch($sformatf("extra store to word %h", mem_addr));
      exp_addr = golden[rec_ptr];
      exp_data = golden[rec_ptr+1];
      exp_mask = golden[rec_ptr+2][3:0];
      got_data = mem_data_in & lane_bits(mem_write_en);
      assert ({2'b00, mem_addr} == exp_addr) else
         report_mismatch($sformatf("store %0d addr %h, expected %h",
                                   rec_cnt, mem_addr, exp_addr));
      assert (mem_write_en == exp_mask) else
         report_mismatch($sformatf("store %0d mask %b, expected %b",
                                   rec_cnt, mem_write_en, exp_mask));
      assert (got_data == exp_data) else
         report_mismatch($sformatf("store %0d data %h, expected %h",
                                   rec_cnt, got_data, exp_data));
      rec_ptr += 3;
      rec_cnt++;
   endtask

   // sampled mid-cycle away from the edges
   always @(negedge clk) begin
      if (rst_b && (mem_write_en != 4'b0000)) begin
         check_store();
      end
   end

   task run_program(input int prog_base, input int n_prog, input int rec_base,
                    input int n_rec, input logic [29:0] final_pc);
      // unused words hold reserved opcodes tagged with their index
      for (int i = 0; i < 64; i++) begin
         imem[i] = (i < n_prog) ? golden[prog_base+i] : (32'hfc00_0000 | i);
      end
      for (int i = 0; i < 256; i++) begin
         dmem[i] = '0;
      end
      rec_ptr   = rec_base;
      rec_cnt   = 0;
      rec_total = n_rec;
      u_clkgen.pulse_reset();
      while (!halted) @(negedge clk);
      assert (inst_addr == final_pc) else
         report_mismatch($sformatf("halt pc word %h, expected %h", inst_addr, final_pc));
      // a few more cycles in which no store may show up
      repeat (4) @(negedge clk);
      assert (halted) else
         report_mismatch("halted dropped after halt");
      assert (rec_cnt == n_rec) else
         report_mismatch($sformatf("%0d stores seen, expected %0d", rec_cnt, n_rec));
   endtask

   initial begin
      limit_cycles = 0;
      rec_total    = 0;
      $readmemh("mips_golden.txt", golden);
      // budget for both runs and their resets
      limit_cycles = 4 * (golden[0] + golden[3]) + 100 + 20;
      run_program(16, golden[0], 64, golden[1], golden[2][29:0]);
      run_program(112, golden[3], 120, golden[4], golden[5][29:0]);
      $display("STATUS: PASS");
      $finish;
   end

   initial begin
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge clk);
      $display("timeout: the core did not halt within %0d cycles", limit_cycles);
      abort_run();
   end

endmodule

`default_nettype wire

//--- mips_golden.txt
// header: prog A length, A store count, A halt pc word, prog B length, B count, B halt pc
// records: word address, data (lanes outside the mask zero), lane mask
@000
00000025 0000000f 00100023 00000004 00000001 00100002
// program A: alu, immediates, lanes, branches, jal, syscalls
@010
24081234 2409fffd 01095021 ac0a0100
01285022 ac0a0104 0128502a ac0a0108
00095043 ac0a010c 01095006 ac0a0110
3c0b8765 356bf00f ac0b0114 01605027
ac0a0118 a00b0121 a40b0122 800c0122
ac0c011c 940c0122 ac0c011c 11090002
ac08012c ac090130 05200002 ac080134
ac080138 0c100020 ac1f013c ac000140
24020004 0000000c 2402000a 0000000c
ac020140
// store records of program A
@040
00000040 00001231 0000000f
00000041 ffffedc9 0000000f
00000042 00000001 0000000f
00000043 fffffffe 0000000f
00000044 00000fff 0000000f
00000045 8765f00f 0000000f
00000046 789a0ff0 0000000f
00000048 000f0000 00000004
00000048 0000f00f 00000003
00000047 fffffff0 0000000f
00000047 0000f00f 0000000f
0000004b 00001234 0000000f
0000004c fffffffd 0000000f
0000004d 00001234 0000000f
0000004f 0040007c 0000000f
// program B: one store, then an undefined opcode
@070
24080005 ac080100 fc000000 ac080104
// store records of program B
@078
00000040 00000005 0000000f

//--- files.f
+incdir+.
mips_isa_pkg.sv
mips_ctrl_pkg.sv
mips_ctrl_if.sv
mips_decode.sv
mips_alu.sv
mips_regfile.sv
mips_mem_align.sv
mips_core.sv
tb_clkgen.sv
tb_mips_core.sv

//--- Bender.yml
package:
  name: mips_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mips_isa_pkg.sv
      - mips_ctrl_pkg.sv
      - mips_ctrl_if.sv
      - mips_decode.sv
      - mips_alu.sv
      - mips_regfile.sv
      - mips_mem_align.sv
      - mips_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - tb_mips_core.sv
